//--- verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // major opcodes, named after the slice they are compared with
    // inst[31:20]
    localparam logic [11:0] op_alu3r     = 12'h001;
    localparam logic [11:0] op_shift_imm = 12'h004;
    // inst[31:25]
    localparam logic [6:0]  op_lu12i     = 7'h0a;
    localparam logic [6:0]  op_pcaddu12i = 7'h0e;
    // inst[31:26]
    localparam logic [5:0]  op_alui      = 6'h00;
    localparam logic [5:0]  op_ldst      = 6'h0a;
    localparam logic [5:0]  op_jirl      = 6'h13;
    localparam logic [5:0]  op_b         = 6'h14;
    localparam logic [5:0]  op_bl        = 6'h15;
    localparam logic [5:0]  op_beq       = 6'h16;
    localparam logic [5:0]  op_bne       = 6'h17;
    localparam logic [5:0]  op_blt       = 6'h18;
    localparam logic [5:0]  op_bge       = 6'h19;
    localparam logic [5:0]  op_bltu      = 6'h1a;
    localparam logic [5:0]  op_bgeu      = 6'h1b;

    // minor opcodes in inst[19:15]
    localparam logic [4:0]  fn_add  = 5'h00;
    localparam logic [4:0]  fn_sub  = 5'h02;
    localparam logic [4:0]  fn_slt  = 5'h04;
    localparam logic [4:0]  fn_sltu = 5'h05;
    localparam logic [4:0]  fn_nor  = 5'h08;
    localparam logic [4:0]  fn_and  = 5'h09;
    localparam logic [4:0]  fn_or   = 5'h0a;
    localparam logic [4:0]  fn_xor  = 5'h0b;
    localparam logic [4:0]  fn_slli = 5'h01;
    localparam logic [4:0]  fn_srli = 5'h09;
    localparam logic [4:0]  fn_srai = 5'h11;

    // minor opcodes in inst[25:22]
    localparam logic [3:0]  alui_slti  = 4'h8;
    localparam logic [3:0]  alui_sltui = 4'h9;
    localparam logic [3:0]  alui_addi  = 4'ha;
    localparam logic [3:0]  alui_andi  = 4'hd;
    localparam logic [3:0]  alui_ori   = 4'he;
    localparam logic [3:0]  alui_xori  = 4'hf;
    localparam logic [3:0]  ldst_ld_w  = 4'h2;
    localparam logic [3:0]  ldst_st_w  = 4'h6;

    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]       word_t;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor, alu_or,
        alu_xor, alu_sll, alu_srl, alu_sra, alu_lui, alu_pcadd
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jump, br_jirl
    } br_kind_e;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_bus_t;

    // one later stage's forwarding offer
    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    result;
    } fwd_src_t;

    typedef struct packed {
        logic     we;
        reg_idx_t waddr;
        word_t    wdata;
    } rf_write_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     src2_is_4;
        logic     res_from_mem;
        logic     mem_we;
        logic     gr_we;
        reg_idx_t dest;
        br_kind_e br_kind;
        logic     use_rj;
        logic     use_rk;
        logic     use_rd;
    } decode_ctrl_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     src2_is_4;
        logic     res_from_mem;
        logic     mem_we;
        logic     gr_we;
        reg_idx_t dest;
        word_t    imm;
        word_t    rj_value;
        word_t    rkd_value;
        word_t    pc;
    } issue_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_bus_t;

endpackage

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder
    import decode_pkg::*;
(
    input  word_t        inst,
    input  word_t        pc,
    output decode_ctrl_t ctrl,
    output word_t        imm,
    output word_t        br_offs,
    output word_t        jirl_offs,
    output reg_idx_t     rj,
    output reg_idx_t     rk,
    output reg_idx_t     rd
);

    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        need_ui5;
    logic        need_ui12;
    logic        need_si20;
    logic        need_si26;

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        ctrl      = '0;
        need_ui5  = 1'b0;
        need_ui12 = 1'b0;
        need_si20 = 1'b0;
        need_si26 = 1'b0;
        if (inst[31:20] == op_alu3r) begin
            ctrl.gr_we  = 1'b1;
            ctrl.use_rj = 1'b1;
            ctrl.use_rk = 1'b1;
            case (inst[19:15])
                fn_add:  ctrl.alu_op = alu_add;
                fn_sub:  ctrl.alu_op = alu_sub;
                fn_slt:  ctrl.alu_op = alu_slt;
                fn_sltu: ctrl.alu_op = alu_sltu;
                fn_nor:  ctrl.alu_op = alu_nor;
                fn_and:  ctrl.alu_op = alu_and;
                fn_or:   ctrl.alu_op = alu_or;
                fn_xor:  ctrl.alu_op = alu_xor;
                default: ctrl = '0;
            endcase
        end else if (inst[31:20] == op_shift_imm) begin
            ctrl.gr_we       = 1'b1;
            ctrl.use_rj      = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            need_ui5         = 1'b1;
            case (inst[19:15])
                fn_slli: ctrl.alu_op = alu_sll;
                fn_srli: ctrl.alu_op = alu_srl;
                fn_srai: ctrl.alu_op = alu_sra;
                default: ctrl = '0;
            endcase
        end else if (inst[31:25] == op_lu12i || inst[31:25] == op_pcaddu12i) begin
            ctrl.gr_we       = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            need_si20        = 1'b1;
            // pcaddu12i adds the upper immediate to pc
            ctrl.src1_is_pc  = (inst[31:25] == op_pcaddu12i);
            ctrl.alu_op      = ctrl.src1_is_pc ? alu_pcadd : alu_lui;
        end else if (inst[31:26] == op_alui) begin
            ctrl.gr_we       = 1'b1;
            ctrl.use_rj      = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            case (inst[25:22])
                alui_addi:  ctrl.alu_op = alu_add;
                alui_slti:  ctrl.alu_op = alu_slt;
                alui_sltui: ctrl.alu_op = alu_sltu;
                alui_andi:  ctrl.alu_op = alu_and;
                alui_ori:   ctrl.alu_op = alu_or;
                alui_xori:  ctrl.alu_op = alu_xor;
                default:    ctrl = '0;
            endcase
            need_ui12 = ctrl.alu_op inside {alu_and, alu_or, alu_xor};
        end else if (inst[31:26] == op_ldst) begin
            // address is rj + si12 in both cases
            ctrl.gr_we        = (inst[25:22] == ldst_ld_w);
            ctrl.res_from_mem = (inst[25:22] == ldst_ld_w);
            ctrl.mem_we       = (inst[25:22] == ldst_st_w);
            ctrl.use_rd       = (inst[25:22] == ldst_st_w);
            ctrl.use_rj       = ctrl.gr_we || ctrl.mem_we;
            ctrl.src2_is_imm  = ctrl.use_rj;
        end else begin
            case (inst[31:26])
                op_jirl: begin
                    ctrl.br_kind = br_jirl;
                    ctrl.use_rj  = 1'b1;
                end
                op_b:    ctrl.br_kind = br_jump;
                op_bl:   ctrl.br_kind = br_jump;
                op_beq:  ctrl.br_kind = br_beq;
                op_bne:  ctrl.br_kind = br_bne;
                op_blt:  ctrl.br_kind = br_blt;
                op_bge:  ctrl.br_kind = br_bge;
                op_bltu: ctrl.br_kind = br_bltu;
                op_bgeu: ctrl.br_kind = br_bgeu;
                default: ctrl.br_kind = br_none;
            endcase
            need_si26 = (inst[31:26] == op_b) || (inst[31:26] == op_bl);
            // link register gets pc + 4
            if (inst[31:26] == op_jirl || inst[31:26] == op_bl) begin
                ctrl.gr_we       = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.src2_is_4   = 1'b1;
            end
            ctrl.use_rd = ctrl.br_kind inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
            ctrl.use_rj = ctrl.use_rj || ctrl.use_rd;
        end

        if (!ctrl.gr_we) begin
            ctrl.dest = '0;
        end else if (need_si26) begin
            ctrl.dest = 5'd1;
        end else begin
            ctrl.dest = rd;
        end
    end

    always_comb begin
        if (ctrl.src2_is_4) begin
            imm = 32'd4;
        end else if (need_si20) begin
            imm = {i20, 12'b0};
        end else if (need_ui5) begin
            imm = {27'b0, rk};
        end else if (need_ui12) begin
            imm = {20'b0, i12};
        end else begin
            imm = {{20{i12[11]}}, i12};
        end
    end

    assign br_offs   = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b0};

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
    import decode_pkg::*;
(
    input  logic      clk,
    input  reg_idx_t  raddr1,
    input  reg_idx_t  raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  rf_write_t wr
);

    word_t regs [num_regs];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass
    import decode_pkg::*;
(
    input  reg_idx_t rj,
    input  reg_idx_t rk,
    input  reg_idx_t rd,
    input  logic     use_rj,
    input  logic     use_rk,
    input  logic     use_rd,
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    input  fwd_src_t es_fwd,
    input  fwd_src_t ms_fwd,
    input  fwd_src_t ws_fwd,
    input  logic     es_is_load,
    output word_t    rj_value,
    output word_t    rkd_value,
    output logic     stall
);

    reg_idx_t rkd_idx;
    logic     rj_act;
    logic     rkd_act;

    // youngest matching stage wins
    function automatic word_t forward(
        input reg_idx_t idx,
        input word_t    rf_val,
        input fwd_src_t es,
        input fwd_src_t ms,
        input fwd_src_t ws
    );
        word_t val;
        if (es.valid && es.dest == idx) begin
            val = es.result;
        end else if (ms.valid && ms.dest == idx) begin
            val = ms.result;
        end else if (ws.valid && ws.dest == idx) begin
            val = ws.result;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rkd_idx = use_rd ? rd : rk;
    assign rj_act  = use_rj && (rj != '0);
    assign rkd_act = (use_rk || use_rd) && (rkd_idx != '0);

    assign rj_value  = rj_act ? forward(rj, rf_rdata1, es_fwd, ms_fwd, ws_fwd) : rf_rdata1;
    assign rkd_value = rkd_act ? forward(rkd_idx, rf_rdata2, es_fwd, ms_fwd, ws_fwd)
                               : rf_rdata2;

    // load data only exists after mem, so an es match has to wait
    assign stall = es_is_load && es_fwd.valid &&
                   ((rj_act && es_fwd.dest == rj) || (rkd_act && es_fwd.dest == rkd_idx));

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit
    import decode_pkg::*;
(
    input  br_kind_e    br_kind,
    input  word_t       pc,
    input  word_t       rj_value,
    input  word_t       rkd_value,
    input  word_t       br_offs,
    input  word_t       jirl_offs,
    input  logic        enable,
    output branch_bus_t br
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            br_beq:  cond = eq;
            br_bne:  cond = !eq;
            br_blt:  cond = lt;
            br_bge:  cond = !lt;
            br_bltu: cond = ltu;
            br_bgeu: cond = !ltu;
            br_jump: cond = 1'b1;
            br_jirl: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br.taken  = enable && cond;
    // jirl is register-relative, the rest pc-relative
    assign br.target = (br_kind == br_jirl) ? rj_value + jirl_offs : pc + br_offs;

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_valid,
    input  fetch_bus_t  fetch_bus,
    output logic        ds_allowin,
    input  logic        es_allowin,
    input  logic        es_is_load,
    input  fwd_src_t    es_fwd,
    input  fwd_src_t    ms_fwd,
    input  fwd_src_t    ws_fwd,
    input  rf_write_t   rf_write,
    output logic        ds_to_es_valid,
    output issue_bus_t  issue,
    output branch_bus_t br
);

    logic         ds_valid;
    logic         ds_ready;
    logic         stall;
    fetch_bus_t   ds_fetch;
    decode_ctrl_t ctrl;
    word_t        imm;
    word_t        br_offs;
    word_t        jirl_offs;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        rj_value;
    word_t        rkd_value;
    reg_idx_t     rj;
    reg_idx_t     rk;
    reg_idx_t     rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_fetch <= fetch_bus;
        end
    end

    assign ds_ready       = ds_valid && !stall;
    assign ds_allowin     = !ds_valid || (ds_ready && es_allowin);
    assign ds_to_es_valid = ds_ready;

    inst_decoder u_decoder (
        .inst      (ds_fetch.inst),
        .pc        (ds_fetch.pc),
        .ctrl      (ctrl),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .rj        (rj),
        .rk        (rk),
        .rd        (rd)
    );

    // stores and branches read rd on the second port
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (ctrl.use_rd ? rd : rk),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_write)
    );

    operand_bypass u_bypass (
        .rj         (rj),
        .rk         (rk),
        .rd         (rd),
        .use_rj     (ctrl.use_rj),
        .use_rk     (ctrl.use_rk),
        .use_rd     (ctrl.use_rd),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_is_load (es_is_load),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .stall      (stall)
    );

    branch_unit u_branch (
        .br_kind   (ctrl.br_kind),
        .pc        (ds_fetch.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .enable    (ds_ready),
        .br        (br)
    );

    always_comb begin
        issue.alu_op       = ctrl.alu_op;
        issue.src1_is_pc   = ctrl.src1_is_pc;
        issue.src2_is_imm  = ctrl.src2_is_imm;
        issue.src2_is_4    = ctrl.src2_is_4;
        issue.res_from_mem = ctrl.res_from_mem;
        // no side effects from an empty slot
        issue.mem_we       = ctrl.mem_we && ds_valid;
        issue.gr_we        = ctrl.gr_we && ds_valid;
        issue.dest         = ctrl.dest;
        issue.imm          = imm;
        issue.rj_value     = rj_value;
        issue.rkd_value    = rkd_value;
        issue.pc           = ds_fetch.pc;
    end

endmodule

`default_nettype wire

//--- sim/id_stage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_assert
    import decode_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        ds_valid,
    input logic        stall,
    input logic        es_allowin,
    input logic        ds_allowin,
    input logic        ds_to_es_valid,
    input issue_bus_t  issue,
    input branch_bus_t br
);

    // a stalled branch must not redirect fetch
    no_taken_in_stall: assert property (@(posedge clk) disable iff (reset)
        !(br.taken && stall))
        else $error("branch taken during a load-use stall");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!ds_to_es_valid && !br.taken && ds_allowin))
        else $error("stage outputs active right after reset");

    issue_stable: assert property (@(posedge clk) disable iff (reset)
        (ds_valid && !es_allowin) |=> $stable(issue))
        else $error("issue bus changed while held by execute");

endmodule

bind id_stage id_stage_assert u_id_stage_assert (
    .clk            (clk),
    .reset          (reset),
    .ds_valid       (ds_valid),
    .stall          (stall),
    .es_allowin     (es_allowin),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .issue          (issue),
    .br             (br)
);

`default_nettype wire

//--- sim/id_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb
    import decode_pkg::*;
();

    localparam int num_insts   = 300;
    localparam int stim_cycles = 36 + 3 * num_insts;
    localparam int max_cycles  = 4 * stim_cycles;

    logic        clk;
    logic        reset;
    logic        fs_valid;
    fetch_bus_t  fetch_bus;
    logic        ds_allowin;
    logic        es_allowin;
    logic        es_is_load;
    fwd_src_t    es_fwd;
    fwd_src_t    ms_fwd;
    fwd_src_t    ws_fwd;
    rf_write_t   rf_write;
    logic        ds_to_es_valid;
    issue_bus_t  issue;
    branch_bus_t br;

    integer seed = 32'h8cceadad;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cur_idx;
    word_t  shadow [num_regs];
    word_t  rnd;
    word_t  inst;

    // reference decode of the instruction in the stage
    issue_bus_t want;
    logic       want_use_rj;
    logic       want_use_rkd;
    logic       want_stall;
    reg_idx_t   cur_rj;
    reg_idx_t   want_rkd_idx;
    word_t      want_offs;

    // LoongArch base encodings, index order matches expected_alu
    word_t bases [30] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000,
        32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0040_8000, 32'h0044_8000,
        32'h0048_8000, 32'h0200_0000, 32'h0240_0000, 32'h0280_0000, 32'h0340_0000,
        32'h0380_0000, 32'h03c0_0000, 32'h1400_0000, 32'h1c00_0000, 32'h2880_0000,
        32'h2980_0000, 32'h4c00_0000, 32'h5000_0000, 32'h5400_0000, 32'h5800_0000,
        32'h5c00_0000, 32'h6000_0000, 32'h6400_0000, 32'h6800_0000, 32'h6c00_0000
    };

    id_stage id_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fetch_bus      (fetch_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .es_is_load     (es_is_load),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rf_write       (rf_write),
        .ds_to_es_valid (ds_to_es_valid),
        .issue          (issue),
        .br             (br)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic alu_op_e expected_alu(input int idx);
        case (idx)
            1:       return alu_sub;
            2, 11:   return alu_slt;
            3, 12:   return alu_sltu;
            4:       return alu_nor;
            5, 14:   return alu_and;
            6, 15:   return alu_or;
            7, 16:   return alu_xor;
            8:       return alu_sll;
            9:       return alu_srl;
            10:      return alu_sra;
            17:      return alu_lui;
            18:      return alu_pcadd;
            default: return alu_add;
        endcase
    endfunction

    function automatic logic branch_cond(input int idx, input word_t a, input word_t b);
        case (idx)
            21, 22, 23: return 1'b1;
            24:         return a == b;
            25:         return a != b;
            26:         return $signed(a) < $signed(b);
            27:         return $signed(a) >= $signed(b);
            28:         return a < b;
            29:         return a >= b;
            default:    return 1'b0;
        endcase
    endfunction

    // es first, then ms, then ws, else the shadow register
    function automatic word_t expected_operand(input reg_idx_t idx);
        if (idx == '0) return '0;
        if (es_fwd.valid && es_fwd.dest == idx) return es_fwd.result;
        if (ms_fwd.valid && ms_fwd.dest == idx) return ms_fwd.result;
        if (ws_fwd.valid && ws_fwd.dest == idx) return ws_fwd.result;
        return shadow[idx];
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t expect_v);
        checks++;
        assert (got === expect_v) else begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, expect_v);
        end
    endtask

    task automatic make_inst(input int idx, input word_t fields, input word_t pc);
        reg_idx_t rd;
        reg_idx_t rk;
        word_t    mask;
        if (idx <= 10) mask = 32'h0000_7fff;
        else if (idx == 17 || idx == 18) mask = 32'h01ff_ffff;
        else if (idx <= 20) mask = 32'h003f_ffff;
        else mask = 32'h03ff_ffff;
        inst   = bases[idx] | (fields & mask);
        rd     = inst[4:0];
        cur_rj = inst[9:5];
        rk     = inst[14:10];
        want           = '0;
        want.pc        = pc;
        want.alu_op    = expected_alu(idx);
        want.imm       = {{20{inst[21]}}, inst[21:10]};
        want_use_rj    = 1'b0;
        want_use_rkd   = 1'b0;
        want_rkd_idx   = rk;
        want_offs      = {{14{inst[25]}}, inst[25:10], 2'b00};
        if (idx <= 7) begin
            want.gr_we   = 1'b1;
            want_use_rj  = 1'b1;
            want_use_rkd = 1'b1;
        end else if (idx <= 16) begin
            want.gr_we       = 1'b1;
            want.src2_is_imm = 1'b1;
            want_use_rj      = 1'b1;
            if (idx <= 10) want.imm = {27'b0, rk};
            else if (idx >= 14) want.imm = {20'b0, inst[21:10]};
        end else if (idx <= 18) begin
            want.gr_we       = 1'b1;
            want.src2_is_imm = 1'b1;
            want.src1_is_pc  = (idx == 18);
            want.imm         = {inst[24:5], 12'b0};
        end else if (idx <= 20) begin
            want.src2_is_imm  = 1'b1;
            want_use_rj       = 1'b1;
            want.gr_we        = (idx == 19);
            want.res_from_mem = (idx == 19);
            want.mem_we       = (idx == 20);
            want_use_rkd      = (idx == 20);
            want_rkd_idx      = rd;
        end else begin
            want_use_rj  = (idx == 21) || (idx >= 24);
            want_use_rkd = (idx >= 24);
            want_rkd_idx = rd;
            if (idx == 22 || idx == 23) begin
                want_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            end
            if (idx == 21 || idx == 23) begin
                want.gr_we       = 1'b1;
                want.src1_is_pc  = 1'b1;
                want.src2_is_imm = 1'b1;
                want.src2_is_4   = 1'b1;
                want.imm         = 32'd4;
            end
        end
        if (want.gr_we) begin
            want.dest = (idx == 23) ? 5'd1 : rd;
        end
    endtask

    // mostly aimed at the operands of the current instruction
    task automatic make_offer(output fwd_src_t f);
        word_t r;
        r = $random(seed);
        f.valid = (r[1:0] != 2'b00);
        case (r[3:2])
            2'd0:    f.dest = cur_rj;
            2'd1:    f.dest = want_rkd_idx;
            default: f.dest = r[8:4];
        endcase
        f.result = $random(seed);
    endtask

    task automatic check_stage();
        word_t a;
        word_t b;
        a = expected_operand(cur_rj);
        b = expected_operand(want_rkd_idx);
        want_stall = es_is_load && es_fwd.valid &&
            ((want_use_rj && cur_rj != '0 && es_fwd.dest == cur_rj) ||
             (want_use_rkd && want_rkd_idx != '0 && es_fwd.dest == want_rkd_idx));
        check_val("ds_to_es_valid", word_t'(ds_to_es_valid), word_t'(!want_stall));
        check_val("ds_allowin", word_t'(ds_allowin), word_t'(!want_stall && es_allowin));
        check_val("br.taken", word_t'(br.taken),
                  word_t'(!want_stall && branch_cond(cur_idx, a, b)));
        check_val("issue.alu_op", word_t'(issue.alu_op), word_t'(want.alu_op));
        check_val("issue.src1_is_pc", word_t'(issue.src1_is_pc), word_t'(want.src1_is_pc));
        check_val("issue.src2_is_imm", word_t'(issue.src2_is_imm), word_t'(want.src2_is_imm));
        check_val("issue.src2_is_4", word_t'(issue.src2_is_4), word_t'(want.src2_is_4));
        check_val("issue.res_from_mem", word_t'(issue.res_from_mem),
                  word_t'(want.res_from_mem));
        check_val("issue.mem_we", word_t'(issue.mem_we), word_t'(want.mem_we));
        check_val("issue.gr_we", word_t'(issue.gr_we), word_t'(want.gr_we));
        check_val("issue.dest", word_t'(issue.dest), word_t'(want.dest));
        check_val("issue.imm", issue.imm, want.imm);
        check_val("issue.pc", issue.pc, want.pc);
        if (want_use_rj) check_val("issue.rj_value", issue.rj_value, a);
        if (want_use_rkd) check_val("issue.rkd_value", issue.rkd_value, b);
        if (cur_idx >= 21) begin
            check_val("br.target", br.target,
                      (cur_idx == 21) ? a + want_offs : want.pc + want_offs);
        end
    endtask

    initial begin
        reset      = 1'b1;
        fs_valid   = 1'b0;
        fetch_bus  = '0;
        es_allowin = 1'b1;
        es_is_load = 1'b0;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_fwd     = '0;
        rf_write   = '0;
        shadow[0]  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // fill every register once so nothing reads as unknown
        for (int r = 1; r < num_regs; r++) begin
            @(negedge clk);
            rf_write.we    = 1'b1;
            rf_write.waddr = reg_idx_t'(r);
            rf_write.wdata = $random(seed);
            shadow[r]      = rf_write.wdata;
        end

        for (int n = 0; n < num_insts; n++) begin
            @(negedge clk);
            rnd     = $random(seed);
            cur_idx = rnd % 30;
            rnd     = $random(seed);
            make_inst(cur_idx, $random(seed), rnd & 32'hffff_fffc);
            fs_valid       = 1'b1;
            fetch_bus.inst = inst;
            fetch_bus.pc   = want.pc;
            es_allowin     = 1'b1;
            es_is_load     = 1'b0;
            es_fwd         = '0;
            ms_fwd         = '0;
            ws_fwd         = '0;
            rnd            = $random(seed);
            rf_write.we    = 1'b1;
            rf_write.waddr = rnd[4:0];
            rf_write.wdata = $random(seed);
            if (rnd[4:0] != '0) shadow[rnd[4:0]] = rf_write.wdata;
            #10;
            check_val("ds_to_es_valid", word_t'(ds_to_es_valid), '0);
            check_val("br.taken", word_t'(br.taken), '0);
            check_val("ds_allowin", word_t'(ds_allowin), 32'd1);
            // the held instruction may still decode as a write
            check_val("issue.gr_we", word_t'(issue.gr_we), '0);
            check_val("issue.mem_we", word_t'(issue.mem_we), '0);

            @(negedge clk);
            fs_valid = 1'b0;
            rf_write = '0;
            make_offer(es_fwd);
            make_offer(ms_fwd);
            make_offer(ws_fwd);
            rnd        = $random(seed);
            es_is_load = (rnd[1:0] == 2'b00);
            es_allowin = (rnd[3:2] != 2'b00);
            #10;
            check_stage();
            if (want_stall || !es_allowin) begin
                @(negedge clk);
                es_is_load = 1'b0;
                es_allowin = 1'b1;
                #10;
                check_stage();
            end
        end

        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/decode_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/id_stage.sv
sim/id_stage_assert.sv
sim/id_stage_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module id_stage_tb -f compile.f -o id_stage_sim
	./obj_dir/id_stage_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
